// ==== core_control.sv ====
`timescale 1ns/1ps

module core_control
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     inst_valid,
    input  inst_t    inst,
    output logic     inst_take,
    output logic     flush,
    output byte_t    jump_pc,
    output reg_idx_t raddr_a,
    output reg_idx_t raddr_b,
    input  byte_t    rdata_a,
    input  byte_t    rdata_b,
    output logic     issue,
    output opcode_t  op,
    output byte_t    addr,
    output byte_t    val1,
    output byte_t    val2,
    input  logic     busy,
    input  logic     done,
    input  byte_t    result,
    output logic     reg_we,
    output reg_idx_t reg_waddr,
    output byte_t    reg_wdata
);

    opcode_t  pend_op;
    reg_idx_t pend_dst;
    logic     is_jump;
    logic     is_exec;
    logic     is_nop;
    logic     exec_free;

    assign is_jump   = (inst.op == op_jmp);
    assign is_exec   = inst.op inside {op_lod, op_str, op_add};
    assign is_nop    = !is_jump && !is_exec;
    assign exec_free = !busy && !done;   // writeback lands before next issue.

    // store reads reg0, add reads reg1 and reg2.
    assign raddr_a = (inst.op == op_str) ? inst.reg0 : inst.low.regs.reg1;
    assign raddr_b = inst.low.regs.reg2;

    assign flush     = inst_valid && is_jump;
    assign jump_pc   = inst.low.addr;
    assign issue     = inst_valid && is_exec && exec_free;
    assign inst_take = flush || issue || (inst_valid && is_nop);

    assign op   = inst.op;
    assign addr = inst.low.addr;
    assign val1 = rdata_a;
    assign val2 = rdata_b;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pend_op <= op_jmp;
        end else begin
            if (issue) begin
                pend_op <= inst.op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pend_dst <= inst.reg0;
        end
    end

    // only load and add write a register.
    assign reg_we    = done && ((pend_op == op_lod) || (pend_op == op_add));
    assign reg_waddr = pend_dst;
    assign reg_wdata = result;

    // after a jump the fetch buffer is empty.
    a_jump_clears: assert property (@(posedge clk) disable iff (!rst)
        flush |=> !inst_valid);

endmodule

// ==== cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker
    import isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_out,
    input  mem_rsp_t mem_in,
    output logic     halted,
    output int       error_count,
    output int       tests_failed
);

    typedef struct packed {
        byte_t addr;
        byte_t data;
    } store_t;

    byte_t    image [256];
    byte_t    fetch_q [$];     // byte addresses in fetch order.
    byte_t    load_q [$];
    store_t   store_q [$];
    string    test_name;
    byte_t    halt_pc;
    int       halt_reads;
    int       stores_seen;
    int       stores_expected;
    int       loads_expected;
    int       errors_at_start;
    logic     running;
    logic     pending;         // request seen without ready.
    mem_req_t held;

    initial begin
        error_count  = 0;
        tests_failed = 0;
        halt_reads   = 0;
        running      = 1'b0;
        pending      = 1'b0;
    end

    assign halted = (halt_reads >= 3);

    task automatic set_image_byte(input int a, input byte_t d);
        image[a] = d;
    endtask

    task automatic value_error(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("** Error %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
        error_count++;
    endtask

    task automatic flow_error(input string msg);
        $display("%s: %s", test_name, msg);
        error_count++;
    endtask

    // runs the instruction set over the image and queues every expected access.
    task automatic start_test(input int idx);
        byte_t  regs [16];
        byte_t  mem [256];
        byte_t  pc;
        byte_t  next_pc;
        byte_t  hi;
        byte_t  lo;
        store_t st;
        logic   found;
        int     steps;
        test_name = $sformatf("test_%0d", idx);
        fetch_q.delete();
        load_q.delete();
        store_q.delete();
        foreach (regs[i]) regs[i] = 8'h00;
        foreach (mem[i]) mem[i] = image[i];
        pc    = 8'h00;
        found = 1'b0;
        steps = 0;
        while (!found && steps < 128) begin
            hi = mem[pc];
            lo = mem[pc + 8'd1];
            fetch_q.push_back(pc);
            fetch_q.push_back(pc + 8'd1);
            next_pc = pc + 8'd2;
            case (hi[7:4])
                4'h0: begin
                    found   = (lo == pc);   // jump to itself.
                    next_pc = lo;
                end
                4'h1: begin
                    load_q.push_back(lo);
                    regs[hi[3:0]] = mem[lo];
                end
                4'h2: begin
                    st.addr = lo;
                    st.data = regs[hi[3:0]];
                    store_q.push_back(st);
                    mem[lo] = st.data;
                end
                4'h3: regs[hi[3:0]] = regs[lo[7:4]] + regs[lo[3:0]];
                default: ;
            endcase
            if (found) halt_pc = pc;
            pc = next_pc;
            steps++;
        end
        if (!found) flow_error("the program has no reachable halt");
        stores_expected = store_q.size();
        loads_expected  = load_q.size();
        stores_seen     = 0;
        halt_reads      = 0;
        pending         = 1'b0;
        errors_at_start = error_count;
        running         = 1'b1;
    endtask

    task automatic check_access();
        store_t exp_st;
        byte_t  exp_addr;
        if (mem_out.we) begin
            stores_seen++;
            if (store_q.size() == 0) begin
                flow_error("a write reached memory with no store left in the model");
            end else begin
                exp_st = store_q.pop_front();
                if (mem_out.addr !== exp_st.addr)
                    value_error("store address", exp_st.addr, mem_out.addr);
                if (mem_out.wdata !== exp_st.data)
                    value_error("store data", exp_st.data, mem_out.wdata);
            end
        end else if (mem_out.addr[7]) begin     // data half of memory.
            if (load_q.size() == 0) begin
                flow_error("a data read reached memory with no load left in the model");
            end else begin
                exp_addr = load_q.pop_front();
                if (mem_out.addr !== exp_addr) value_error("load address", exp_addr, mem_out.addr);
            end
        end else begin
            if (mem_out.addr == halt_pc) halt_reads++;
            if (fetch_q.size() != 0) begin
                exp_addr = fetch_q.pop_front();
                if (mem_out.addr !== exp_addr)
                    value_error("fetch address", exp_addr, mem_out.addr);
            end else if (mem_out.addr != halt_pc && mem_out.addr != halt_pc + 8'd1) begin
                flow_error("an instruction was fetched past the halt");
            end
        end
    endtask

    task automatic end_test();
        running = 1'b0;
        if (stores_seen != stores_expected) value_error("store count", stores_expected, stores_seen);
        if (fetch_q.size() != 0) flow_error("instructions of the model were never fetched");
        if (load_q.size() != 0) flow_error("loads of the model never reached memory");
        if (error_count == errors_at_start) begin
            $display("%s: ok, %0d stores, %0d loads", test_name, stores_seen, loads_expected);
        end else begin
            tests_failed++;
            $display("%s: failed, %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    always @(posedge clk) begin
        if (rst && running) begin
            if (pending && mem_out !== held) begin
                flow_error("a request changed before the memory answered");
            end
            pending = mem_out.req && !mem_in.ready;
            held    = mem_out;
            if (mem_out.req && mem_in.ready) begin
                check_access();
            end
        end
    end

endmodule

// ==== eightbit_cpu.f ====
isa_pkg.sv
mem_bus_pkg.sv
fetch_unit.sv
exec_unit.sv
reg_file.sv
mem_arbiter.sv
core_control.sv
eightbit_cpu.sv
cpu_checker.sv
tb_eightbit_cpu.sv

// ==== eightbit_cpu.sv ====
`timescale 1ns/1ps

module eightbit_cpu
    import isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output mem_req_t mem_out,
    input  mem_rsp_t mem_in
);

    mem_req_t fetch_bus;
    mem_req_t exec_bus;
    mem_rsp_t fetch_rsp;
    mem_rsp_t exec_rsp;

    logic     flush;
    byte_t    jump_pc;
    logic     inst_take;
    logic     inst_valid;
    inst_t    inst;

    reg_idx_t raddr_a;
    reg_idx_t raddr_b;
    byte_t    rdata_a;
    byte_t    rdata_b;
    logic     reg_we;
    reg_idx_t reg_waddr;
    byte_t    reg_wdata;

    logic     issue;
    opcode_t  op;
    byte_t    addr;
    byte_t    val1;
    byte_t    val2;
    logic     busy;
    logic     done;
    byte_t    result;

    fetch_unit u_fetch (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .jump_pc    (jump_pc),
        .inst_take  (inst_take),
        .bus        (fetch_bus),
        .rsp        (fetch_rsp),
        .inst_valid (inst_valid),
        .inst       (inst)
    );

    exec_unit u_exec (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .op     (op),
        .addr   (addr),
        .val1   (val1),
        .val2   (val2),
        .bus    (exec_bus),
        .rsp    (exec_rsp),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (reg_we),
        .waddr   (reg_waddr),
        .wdata   (reg_wdata)
    );

    mem_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .fetch_bus (fetch_bus),
        .exec_bus  (exec_bus),
        .fetch_rsp (fetch_rsp),
        .exec_rsp  (exec_rsp),
        .mem_out   (mem_out),
        .mem_in    (mem_in)
    );

    core_control u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_take  (inst_take),
        .flush      (flush),
        .jump_pc    (jump_pc),
        .raddr_a    (raddr_a),
        .raddr_b    (raddr_b),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b),
        .issue      (issue),
        .op         (op),
        .addr       (addr),
        .val1       (val1),
        .val2       (val2),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .reg_we     (reg_we),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata)
    );

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
    import isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  opcode_t  op,
    input  byte_t    addr,
    input  byte_t    val1,
    input  byte_t    val2,
    output mem_req_t bus,
    input  mem_rsp_t rsp,
    output logic     busy,
    output logic     done,
    output byte_t    result
);

    typedef enum logic [1:0] {
        ex_idle,
        ex_access,
        ex_finish
    } exec_state_t;

    exec_state_t state;
    opcode_t     op_q;
    byte_t       addr_q;
    byte_t       data_q;      // store data.
    byte_t       result_q;
    logic        accept;
    logic        is_mem;

    assign accept = issue && (state == ex_idle);
    assign is_mem = (op == op_lod) || (op == op_str);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= ex_idle;
        end else begin
            case (state)
                ex_idle: begin
                    if (issue) begin
                        state <= is_mem ? ex_access : ex_finish;
                    end
                end
                ex_access: begin
                    if (rsp.ready) begin
                        state <= ex_finish;
                    end
                end
                ex_finish: state <= ex_idle;
                default:   state <= ex_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= op;
            addr_q <= addr;
            data_q <= val1;
            if (op == op_add) begin
                result_q <= val1 + val2;    // wraps mod 256.
            end
        end
        if (state == ex_access && rsp.ready && op_q == op_lod) begin
            result_q <= rsp.rdata;
        end
    end

    assign bus = '{
        req:   (state == ex_access),
        we:    (state == ex_access) && (op_q == op_str),
        addr:  addr_q,
        wdata: data_q
    };

    assign busy   = (state != ex_idle);
    assign done   = (state == ex_finish);
    assign result = result_q;

    // control must hold off while an instruction is in here.
    a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst)
        issue |-> !busy);

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
    import isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  byte_t    jump_pc,
    input  logic     inst_take,
    output mem_req_t bus,
    input  mem_rsp_t rsp,
    output logic     inst_valid,
    output inst_t    inst
);

    typedef enum logic [1:0] {
        fs_idle,
        fs_high,
        fs_low
    } fetch_state_t;

    fetch_state_t state;
    byte_t        fetch_pc;     // next instruction to fetch.
    byte_t        req_addr;
    byte_t        high_q;
    inst_t        inst_q;
    logic         valid_q;
    logic         start;

    assign start = (state == fs_idle) && !flush && (!valid_q || inst_take);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= fs_idle;
            fetch_pc <= '0;
            valid_q  <= 1'b0;
        end else begin
            if (inst_take || flush) begin
                valid_q <= 1'b0;
            end
            if (flush) begin
                fetch_pc <= jump_pc;
            end
            case (state)
                fs_idle: begin
                    if (start) begin
                        state <= fs_high;
                    end
                end
                fs_high, fs_low: begin
                    if (rsp.ready) begin
                        if (flush) begin
                            state <= fs_idle;   // bus access done, data dropped.
                        end else if (state == fs_high) begin
                            state <= fs_low;
                        end else begin
                            state    <= fs_idle;
                            valid_q  <= 1'b1;
                            fetch_pc <= fetch_pc + inst_bytes;
                        end
                    end
                end
                default: state <= fs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= fetch_pc;
        end else if (state == fs_high && rsp.ready) begin
            req_addr <= req_addr + 8'd1;
        end
        if (state == fs_high && rsp.ready) begin
            high_q <= rsp.rdata;    // lower address is the high half.
        end
        if (state == fs_low && rsp.ready && !flush) begin
            inst_q <= inst_t'({high_q, rsp.rdata});
        end
    end

    assign bus = '{req: (state != fs_idle), we: 1'b0, addr: req_addr, wdata: 8'h00};

    assign inst_valid = valid_q;
    assign inst       = inst_q;

    // the request may not move until the memory answers.
    a_req_stable: assert property (@(posedge clk) disable iff (!rst)
        bus.req && !rsp.ready |=> $stable(bus));

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

    typedef logic [7:0] byte_t;     // data byte or memory address.
    typedef logic [3:0] reg_idx_t;

    // codes 4 to 15 decode as no-operation.
    typedef enum logic [3:0] {
        op_jmp = 4'd0,
        op_lod = 4'd1,
        op_str = 4'd2,
        op_add = 4'd3
    } opcode_t;

    typedef struct packed {
        reg_idx_t reg1;
        reg_idx_t reg2;
    } reg_pair_t;

    // low byte is two source registers, or an address for jmp, lod and str.
    typedef union packed {
        reg_pair_t regs;
        byte_t     addr;
    } inst_low_t;

    typedef struct packed {
        opcode_t   op;
        reg_idx_t  reg0;
        inst_low_t low;
    } inst_t;

    localparam int unsigned num_regs = 16;

    // pc step, wraps at 256.
    localparam byte_t inst_bytes = 8'd2;

endpackage

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t fetch_bus,
    input  mem_req_t exec_bus,
    output mem_rsp_t fetch_rsp,
    output mem_rsp_t exec_rsp,
    output mem_req_t mem_out,
    input  mem_rsp_t mem_in
);

    typedef enum logic [1:0] {
        own_free,
        own_fetch,
        own_exec
    } owner_t;

    owner_t owner;
    owner_t grant;

    // execute first, but only on a free bus.
    always_comb begin
        grant = owner;
        if (owner == own_free) begin
            if (exec_bus.req) begin
                grant = own_exec;
            end else if (fetch_bus.req) begin
                grant = own_fetch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            owner <= own_free;
        end else if (mem_in.ready) begin
            owner <= own_free;     // released on ready.
        end else begin
            owner <= grant;
        end
    end

    always_comb begin
        case (grant)
            own_exec:  mem_out = exec_bus;
            own_fetch: mem_out = fetch_bus;
            default:   mem_out = mem_req_idle;
        endcase
    end

    assign fetch_rsp = '{ready: mem_in.ready && (grant == own_fetch), rdata: mem_in.rdata};
    assign exec_rsp  = '{ready: mem_in.ready && (grant == own_exec), rdata: mem_in.rdata};

    // every ready from memory lands on exactly one master.
    a_one_ready: assert property (@(posedge clk) disable iff (!rst)
        mem_in.ready |-> $onehot({fetch_rsp.ready, exec_rsp.ready}));

endmodule

// ==== mem_bus_pkg.sv ====
package mem_bus_pkg;

    import isa_pkg::*;

    // held stable by the master until it sees ready.
    typedef struct packed {
        logic  req;
        logic  we;
        byte_t addr;
        byte_t wdata;
    } mem_req_t;

    // ready lasts one cycle per access, rdata valid with it.
    typedef struct packed {
        logic  ready;
        byte_t rdata;
    } mem_rsp_t;

    localparam mem_req_t mem_req_idle = '{
        req:   1'b0,
        we:    1'b0,
        addr:  8'h00,
        wdata: 8'h00
    };

endpackage

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output byte_t    rdata_a,
    output byte_t    rdata_b,
    input  logic     we,
    input  reg_idx_t waddr,
    input  byte_t    wdata
);

    byte_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // new value visible from the cycle after the write.
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

// ==== tb_eightbit_cpu.sv ====
`timescale 1ns/1ps

module tb_eightbit_cpu
    import isa_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int          num_tests       = 20;
    localparam int          max_inst        = 60;
    localparam int          watchdog_cycles = num_tests * max_inst * 400;
    localparam logic [31:0] lfsr_seed       = 32'h165f_ec22;
    localparam logic [31:0] lfsr_taps       = 32'h8020_0003;

    logic        clk;
    logic        rst;
    mem_req_t    mem_out;
    mem_rsp_t    mem_in;
    logic        halted;
    int          error_count;
    int          tests_failed;
    logic [31:0] lfsr;
    byte_t       mem [256];
    logic        in_access;
    int          waits_left;

    eightbit_cpu DUT (
        .clk     (clk),
        .rst     (rst),
        .mem_out (mem_out),
        .mem_in  (mem_in)
    );

    cpu_checker chk (
        .clk          (clk),
        .rst          (rst),
        .mem_out      (mem_out),
        .mem_in       (mem_in),
        .halted       (halted),
        .error_count  (error_count),
        .tests_failed (tests_failed)
    );

    always #5 clk = ~clk;

    // galois lfsr, one step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
        end
        return v;
    endfunction

    // memory answers after 0 to 3 wait cycles.
    always @(negedge clk) begin
        mem_in.ready = 1'b0;
        if (!rst || !mem_out.req) begin
            in_access = 1'b0;
        end else begin
            if (!in_access) begin
                waits_left = take_bits(2);
                in_access  = 1'b1;
            end
            if (waits_left == 0) begin
                mem_in.ready = 1'b1;
                mem_in.rdata = mem[mem_out.addr];
                if (mem_out.we) mem[mem_out.addr] = mem_out.wdata;
                in_access = 1'b0;
            end else begin
                waits_left--;
            end
        end
    end

    task automatic write_program();
        int          n;
        int          pc;
        int          halt;
        int          slots;
        logic [15:0] word;
        foreach (mem[a]) mem[a] = take_bits(8);   // data bytes and unused space.
        n    = 29 + take_bits(5);
        halt = 2 * (n - 1);
        for (int i = 0; i < n - 1; i++) begin
            pc = 2 * i;
            case (take_bits(3))
                0: begin
                    slots = (halt - pc) / 2;        // forward targets up to the halt.
                    word  = {op_jmp, 4'(take_bits(4)), 8'(pc + 2 * (1 + take_bits(2) % slots))};
                end
                1, 2:    word = {op_lod, 4'(take_bits(4)), 1'b1, 7'(take_bits(7))};
                3, 4:    word = {op_str, 4'(take_bits(4)), 1'b1, 7'(take_bits(7))};
                5, 6:    word = {op_add, 12'(take_bits(12))};
                default: word = {1'b1, 15'(take_bits(15))};    // no-operation code.
            endcase
            mem[pc]     = word[15:8];
            mem[pc + 1] = word[7:0];
        end
        mem[halt]     = 8'h00;
        mem[halt + 1] = 8'(halt);
    endtask

    initial begin
        clk    = 1'b0;
        rst    = 1'b0;
        mem_in = '0;
        lfsr   = lfsr_seed;
        for (int t = 0; t < num_tests; t++) begin
            @(negedge clk);
            rst = 1'b0;
            write_program();
            foreach (mem[a]) chk.set_image_byte(a, mem[a]);
            chk.start_test(t);
            repeat (4) @(negedge clk);
            rst = 1'b1;
            wait (halted);
            chk.end_test();
        end
        $display("tests run %0d, failed %0d, errors %0d", num_tests, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired, the CPU never reached the halt of its program");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
